/* common/knightPkg.sv */
package knightPkg;

  //////////////////////////////////////////////////////////////////////
  // Command word layout
  //////////////////////////////////////////////////////////////////////

  // Full command from the remote link
  localparam int unsigned CMD_W = 16;

  // Opcode sits in the top nibble
  localparam int unsigned OPC_W = 4;

  // Heading bits carried in the command, just below the opcode
  localparam int unsigned HDG_CMD_W = 8;

  // Square count in the low nibble
  localparam int unsigned SQUARE_W = 4;

  // Internal heading format, command bits land in the top of it
  localparam int unsigned HEADING_W = 12;

  // Forward speed handed to the drive
  localparam int unsigned SPEED_W = 11;

  // Response byte back to the remote
  localparam int unsigned RESP_W = 8;

  //////////////////////////////////////////////////////////////////////
  // Opcodes and responses
  //////////////////////////////////////////////////////////////////////

  localparam logic [OPC_W-1:0] OPC_CAL  = 4'h2;
  localparam logic [OPC_W-1:0] OPC_MOVE = 4'h4;

  // Completed command
  localparam logic [RESP_W-1:0] RESP_ACK = 8'hA5;
  // Unknown or malformed command
  localparam logic [RESP_W-1:0] RESP_NAK = 8'h5A;

  //////////////////////////////////////////////////////////////////////
  // Execute FSM states
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    IDLE,    // waiting for a request
    CAL,     // gyro calibration running
    SETTLE,  // turning onto the new heading
    RAMP,    // speeding up and counting lines
    COAST,   // slowing down to a stop
    DONE     // one cycle of completion
  } execState_t;

endpackage

/* verilog/cmdDecode.sv */
`timescale 1ns/1ps

module cmdDecode (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic [knightPkg::CMD_W-1:0]     cmd,
  input  logic                            cmdRdy,
  input  logic                            busy,
  output logic                            calReq,
  output logic                            moveReq,
  output logic                            badReq,
  output logic [knightPkg::HEADING_W-1:0] heading,
  output logic [knightPkg::SQUARE_W-1:0]  squares
);

  import knightPkg::*;

  logic [OPC_W-1:0]     opcode;
  logic [HDG_CMD_W-1:0] hdgBits;
  logic [SQUARE_W-1:0]  sqBits;
  logic                 accept;
  logic                 isCal;
  logic                 isMove;

  //////////////////////////////////////////////////////////////////////
  // Field split
  //////////////////////////////////////////////////////////////////////

  // Opcode in the top nibble
  assign opcode  = cmd[CMD_W-1 -: OPC_W];
  // Heading byte right below it
  assign hdgBits = cmd[SQUARE_W +: HDG_CMD_W];
  // Square count in the bottom nibble
  assign sqBits  = cmd[SQUARE_W-1:0];

  // A request already in flight counts as busy too,
  // execute only raises busy one cycle after the pulse
  assign accept = cmdRdy && !busy && !calReq && !moveReq;

  assign isCal  = (opcode == OPC_CAL);
  // Moving zero squares is not a legal move
  assign isMove = (opcode == OPC_MOVE) && (sqBits != '0);

  //////////////////////////////////////////////////////////////////////
  // Request pulses
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      calReq  <= 1'b0;
      moveReq <= 1'b0;
      badReq  <= 1'b0;
    end else begin
      // Exactly one of these follows an accepted strobe
      calReq  <= accept && isCal;
      moveReq <= accept && isMove;
      badReq  <= accept && !isCal && !isMove;
    end
  end

  // Payload fields, only meaningful alongside a request pulse
  always_ff @(posedge clk) begin
    if (accept) begin
      // Low nibble of the heading is always zero
      heading <= {hdgBits, {(HEADING_W - HDG_CMD_W){1'b0}}};
      squares <= sqBits;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Never more than one request per cycle
  reqOneHot : assert property (
    @(posedge clk) disable iff (!rstN)
    $onehot0({calReq, moveReq, badReq})
  );

endmodule

/* moveExecute/speedRamp.sv */
`timescale 1ns/1ps

module speedRamp #(
  parameter int unsigned SPEED_INC = 8,
  parameter int unsigned MAX_SPEED = 512
) (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          rampUp,
  input  logic                          rampDown,
  output logic [knightPkg::SPEED_W-1:0] frwrdSpeed,
  output logic                          speedZero
);

  import knightPkg::*;

  // Saturation thresholds, compared before stepping so nothing wraps
  localparam logic [SPEED_W-1:0] TOP_STEP = SPEED_W'(MAX_SPEED - SPEED_INC);
  localparam logic [SPEED_W-1:0] INC      = SPEED_W'(SPEED_INC);

  //////////////////////////////////////////////////////////////////////
  // Speed register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      frwrdSpeed <= '0;
    end else if (rampUp) begin
      // Clip at the ceiling
      if (frwrdSpeed >= TOP_STEP) begin
        frwrdSpeed <= SPEED_W'(MAX_SPEED);
      end else begin
        frwrdSpeed <= frwrdSpeed + INC;
      end
    end else if (rampDown) begin
      // Clip at a standstill
      if (frwrdSpeed <= INC) begin
        frwrdSpeed <= '0;
      end else begin
        frwrdSpeed <= frwrdSpeed - INC;
      end
    end
  end

  // Execute waits on this before completing
  assign speedZero = (frwrdSpeed == '0);

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  speedCeiling : assert property (
    @(posedge clk) disable iff (!rstN)
    frwrdSpeed <= SPEED_W'(MAX_SPEED)
  );

  // Execute never asks for both directions
  rampExclusive : assert property (
    @(posedge clk) disable iff (!rstN)
    !(rampUp && rampDown)
  );

endmodule

/* moveExecute/moveExecute.sv */
`timescale 1ns/1ps

module moveExecute #(
  parameter int unsigned SPEED_INC     = 8,
  parameter int unsigned MAX_SPEED     = 512,
  parameter int unsigned HEADING_TOL   = 48,
  parameter int unsigned SETTLE_CYCLES = 8
) (
  input  logic                                   clk,
  input  logic                                   rstN,
  input  logic                                   calReq,
  input  logic                                   moveReq,
  input  logic        [knightPkg::HEADING_W-1:0] heading,
  input  logic        [knightPkg::SQUARE_W-1:0]  squares,
  input  logic                                   calDone,
  input  logic signed [knightPkg::HEADING_W-1:0] headingErr,
  input  logic                                   lineCross,
  output logic                                   strtCal,
  output logic        [knightPkg::HEADING_W-1:0] desiredHeading,
  output logic                                   moving,
  output logic        [knightPkg::SPEED_W-1:0]   frwrdSpeed,
  output logic                                   busy,
  output logic                                   cmdDone
);

  import knightPkg::*;

  // Counter widths
  localparam int unsigned SETTLE_W = $clog2(SETTLE_CYCLES + 1);
  // Two lines per square needs one extra bit
  localparam int unsigned LINE_W   = SQUARE_W + 1;

  execState_t          state;
  execState_t          nextState;
  logic [SETTLE_W-1:0] settleCnt;
  logic [LINE_W-1:0]   lineCnt;
  logic [LINE_W-1:0]   lineTarget;
  logic [HEADING_W-1:0] absErr;
  logic                inTol;
  logic                settled;
  logic                lastCross;
  logic                rampUp;
  logic                rampDown;
  logic                speedZero;

  //////////////////////////////////////////////////////////////////////
  // Heading settle detect
  //////////////////////////////////////////////////////////////////////

  // Magnitude of the controller error
  assign absErr  = headingErr[HEADING_W-1] ? HEADING_W'(-headingErr) : headingErr;
  assign inTol   = (absErr <= HEADING_W'(HEADING_TOL));
  // Last in-tolerance cycle of the run
  assign settled = inTol && (settleCnt == SETTLE_W'(SETTLE_CYCLES - 1));

  // Final crossing of the move
  assign lastCross = lineCross && (lineCnt + 1'b1 == lineTarget);

  // Ramp commands follow the state directly
  assign rampUp   = (state == RAMP);
  assign rampDown = (state == COAST);

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    nextState = state;
    case (state)
      IDLE: begin
        if (calReq) begin
          nextState = CAL;
        end else if (moveReq) begin
          nextState = SETTLE;
        end
      end
      // Skip the strtCal cycle since the gyro may still show the old done level
      CAL:     if (calDone && !strtCal) nextState = DONE;
      SETTLE:  if (settled) nextState = RAMP;
      RAMP:    if (lastCross) nextState = COAST;
      COAST:   if (speedZero) nextState = DONE;
      DONE:    nextState = IDLE;
      default: nextState = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state          <= IDLE;
      busy           <= 1'b0;
      strtCal        <= 1'b0;
      cmdDone        <= 1'b0;
      moving         <= 1'b0;
      desiredHeading <= '0;
    end else begin
      state   <= nextState;
      busy    <= (nextState != IDLE);
      strtCal <= (state == IDLE) && calReq;
      // High for the single DONE cycle
      cmdDone <= (nextState == DONE);
      if ((state == IDLE) && moveReq) begin
        desiredHeading <= heading;
      end
      // Drive enable from settled heading until the stop
      if ((state == SETTLE) && settled) begin
        moving <= 1'b1;
      end else if (nextState == DONE) begin
        moving <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Settle and line counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      settleCnt  <= '0;
      lineCnt    <= '0;
      lineTarget <= '0;
    end else begin
      // Any out-of-tolerance cycle restarts the run
      if ((state == SETTLE) && inTol && !settled) begin
        settleCnt <= settleCnt + 1'b1;
      end else begin
        settleCnt <= '0;
      end
      if ((state == IDLE) && moveReq) begin
        lineCnt    <= '0;
        lineTarget <= {squares, 1'b0};
      end else if ((state == RAMP) && lineCross) begin
        lineCnt <= lineCnt + 1'b1;
      end
    end
  end

  // Forward speed profile
  speedRamp #(
    .SPEED_INC (SPEED_INC),
    .MAX_SPEED (MAX_SPEED)
  ) iRamp (
    .clk        (clk),
    .rstN       (rstN),
    .rampUp     (rampUp),
    .rampDown   (rampDown),
    .frwrdSpeed (frwrdSpeed),
    .speedZero  (speedZero)
  );

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Stray line pulses between commands are ignored
  idleLineIgnored : assert property (
    @(posedge clk) disable iff (!rstN)
    ((state == IDLE) && lineCross && !moveReq) |=> $stable(lineCnt)
  );

  // Decode relies on busy for the whole command
  // and no new request reaches an active execute
  busyWhenActive : assert property (
    @(posedge clk) disable iff (!rstN)
    (state != IDLE) |-> (busy && !calReq && !moveReq)
  );

endmodule

/* verilog/respGen.sv */
`timescale 1ns/1ps

module respGen (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         cmdDone,
  input  logic                         badReq,
  output logic [knightPkg::RESP_W-1:0] resp,
  output logic                         sendResp
);

  import knightPkg::*;

  //////////////////////////////////////////////////////////////////////
  // Response byte and strobe
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resp     <= '0;
      sendResp <= 1'b0;
    end else begin
      // One strobe per finished or rejected command
      sendResp <= cmdDone || badReq;
      // Byte stays put until the next event
      if (cmdDone) begin
        resp <= RESP_ACK;
      end else if (badReq) begin
        resp <= RESP_NAK;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Decode only accepts while execute is idle,
  // so a rejection cannot land on a completion
  doneBadExclusive : assert property (
    @(posedge clk) disable iff (!rstN)
    !(cmdDone && badReq)
  );

endmodule

/* verilog/knightCmdCore.sv */
`timescale 1ns/1ps

module knightCmdCore #(
  parameter int unsigned SPEED_INC     = 8,
  parameter int unsigned MAX_SPEED     = 512,
  parameter int unsigned HEADING_TOL   = 48,
  parameter int unsigned SETTLE_CYCLES = 8
) (
  input  logic                                   clk,
  input  logic                                   rstN,
  input  logic        [knightPkg::CMD_W-1:0]     cmd,
  input  logic                                   cmdRdy,
  input  logic                                   calDone,
  input  logic signed [knightPkg::HEADING_W-1:0] headingErr,
  input  logic                                   lineCross,
  output logic                                   strtCal,
  output logic        [knightPkg::HEADING_W-1:0] desiredHeading,
  output logic                                   moving,
  output logic        [knightPkg::SPEED_W-1:0]   frwrdSpeed,
  output logic        [knightPkg::RESP_W-1:0]    resp,
  output logic                                   sendResp
);

  import knightPkg::*;

  // Decode to execute
  logic                 calReq;
  logic                 moveReq;
  logic                 badReq;
  logic [HEADING_W-1:0] heading;
  logic [SQUARE_W-1:0]  squares;
  // Execute back to decode and on to result
  logic                 busy;
  logic                 cmdDone;

  //////////////////////////////////////////////////////////////////////
  // Command decode
  //////////////////////////////////////////////////////////////////////

  cmdDecode iDecode (
    .clk     (clk),
    .rstN    (rstN),
    .cmd     (cmd),
    .cmdRdy  (cmdRdy),
    .busy    (busy),
    .calReq  (calReq),
    .moveReq (moveReq),
    .badReq  (badReq),
    .heading (heading),
    .squares (squares)
  );

  //////////////////////////////////////////////////////////////////////
  // Execute, owns the speed ramp
  //////////////////////////////////////////////////////////////////////

  moveExecute #(
    .SPEED_INC     (SPEED_INC),
    .MAX_SPEED     (MAX_SPEED),
    .HEADING_TOL   (HEADING_TOL),
    .SETTLE_CYCLES (SETTLE_CYCLES)
  ) iExecute (
    .clk            (clk),
    .rstN           (rstN),
    .calReq         (calReq),
    .moveReq        (moveReq),
    .heading        (heading),
    .squares        (squares),
    .calDone        (calDone),
    .headingErr     (headingErr),
    .lineCross      (lineCross),
    .strtCal        (strtCal),
    .desiredHeading (desiredHeading),
    .moving         (moving),
    .frwrdSpeed     (frwrdSpeed),
    .busy           (busy),
    .cmdDone        (cmdDone)
  );

  // Response back to the remote
  respGen iResp (
    .clk      (clk),
    .rstN     (rstN),
    .cmdDone  (cmdDone),
    .badReq   (badReq),
    .resp     (resp),
    .sendResp (sendResp)
  );

endmodule

/* testbench/knightCmdCore_tb.sv */
`timescale 1ns/1ps

module knightCmdCore_tb;

  import knightPkg::*;

  // Core configuration handed down to the DUT
  localparam int unsigned SPEED_INC     = 16;
  localparam int unsigned MAX_SPEED     = 410;
  localparam int unsigned HEADING_TOL   = 48;
  localparam int unsigned SETTLE_CYCLES = 6;

  // Upper bound in clocks on any wait for the DUT
  localparam int WAIT_LIMIT = 2000;

  // Unknown opcode that would draw a NAK if the core ever took it
  localparam logic [CMD_W-1:0] STRAY_CMD = 16'hF0F0;

  logic                        clk;
  logic                        rstN;
  logic [CMD_W-1:0]            cmd;
  logic                        cmdRdy;
  logic                        calDone;
  logic signed [HEADING_W-1:0] headingErr;
  logic                        lineCross;
  logic                        strtCal;
  logic [HEADING_W-1:0]        desiredHeading;
  logic                        moving;
  logic [SPEED_W-1:0]          frwrdSpeed;
  logic [RESP_W-1:0]           resp;
  logic                        sendResp;

  // Scoreboard state
  int                 checkCount;
  int                 errCount;
  int                 abortCount;
  int                 respCount;
  int                 pulseCount;
  int                 lineTarget;
  bit                 lastDriven;
  logic               prevMoving;
  logic [SPEED_W-1:0] prevSpeed;
  logic [31:0]        rngState;

  knightCmdCore #(
    .SPEED_INC     (SPEED_INC),
    .MAX_SPEED     (MAX_SPEED),
    .HEADING_TOL   (HEADING_TOL),
    .SETTLE_CYCLES (SETTLE_CYCLES)
  ) i_knightCmdCore (
    .clk            (clk),
    .rstN           (rstN),
    .cmd            (cmd),
    .cmdRdy         (cmdRdy),
    .calDone        (calDone),
    .headingErr     (headingErr),
    .lineCross      (lineCross),
    .strtCal        (strtCal),
    .desiredHeading (desiredHeading),
    .moving         (moving),
    .frwrdSpeed     (frwrdSpeed),
    .resp           (resp),
    .sendResp       (sendResp)
  );

  // 10 ns clock
  initial clk = 1'b0;
  always #5 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t ns", name, got, exp, $time);
    end
  endtask

  // Xorshift32 for the line gap jitter
  function automatic logic [31:0] nextRandom(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // One clock ending on the falling edge where outputs are stable
  task automatic stepCycle();
    @(negedge clk);
    if (sendResp) begin
      respCount++;
    end
    // Ceiling holds at all times
    if (frwrdSpeed > SPEED_W'(MAX_SPEED)) begin
      checkValue("frwrdSpeed", 32'(frwrdSpeed), 32'(MAX_SPEED));
    end
    // No slowing down until the last line pulse is out
    if (!lastDriven && (frwrdSpeed < prevSpeed)) begin
      checkValue("frwrdSpeed", 32'(frwrdSpeed), 32'(prevSpeed));
    end
    // Drive enable may only drop once every crossing was seen
    if (prevMoving && !moving) begin
      checkValue("lineCross count", 32'(pulseCount), 32'(lineTarget));
    end
    prevSpeed  = frwrdSpeed;
    prevMoving = moving;
  endtask

  task automatic reportTimeout(input string what);
    execState_t st;
    st = i_knightCmdCore.iExecute.state;
    abortCount++;
    $display("Timed out waiting for %s, execute FSM in %s", what, st.name());
  endtask

  task automatic sendCommand(input logic [CMD_W-1:0] word);
    cmd    = word;
    cmdRdy = 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Case flows
  //////////////////////////////////////////////////////////////////////

  task automatic runCalCase(input logic [CMD_W-1:0] word, input int gyroDelay,
                            input logic [RESP_W-1:0] expResp);
    int i;
    sendCommand(word);
    // Decode cycle
    stepCycle();
    cmdRdy = 1'b0;
    checkValue("strtCal", 32'(strtCal), 32'd0);
    // Start pulse right after decode
    stepCycle();
    checkValue("strtCal", 32'(strtCal), 32'd1);
    for (i = 0; i < gyroDelay; i++) begin
      stepCycle();
      cmdRdy = 1'b0;
      checkValue("strtCal", 32'(strtCal), 32'd0);
      checkValue("sendResp", 32'(sendResp), 32'd0);
      // Core is busy so this one must vanish
      if ((i == 0) && (gyroDelay > 1)) begin
        sendCommand(STRAY_CMD);
      end
    end
    calDone = 1'b1;
    stepCycle();
    cmdRdy = 1'b0;
    checkValue("sendResp", 32'(sendResp), 32'd0);
    stepCycle();
    checkValue("sendResp", 32'(sendResp), 32'd1);
    checkValue("resp", 32'(resp), 32'(expResp));
    calDone = 1'b0;
  endtask

  task automatic runMoveCase(input logic [CMD_W-1:0] word, input int settleLen,
                             input int gapBase, input logic [RESP_W-1:0] expResp);
    int                          i;
    int                          k;
    int                          gap;
    int                          waitCnt;
    logic signed [HEADING_W-1:0] badErr;
    logic [HEADING_W-1:0]        hdgExp;
    badErr     = HEADING_W'(HEADING_TOL + 1);
    // Command heading byte lands in the top of the 12-bit heading
    hdgExp     = {word[11:4], 4'h0};
    lineTarget = 2 * int'(word[3:0]);
    pulseCount = 0;
    sendCommand(word);
    // Error swings just outside tolerance on both sides
    for (i = 0; i < settleLen; i++) begin
      headingErr = i[0] ? -badErr : badErr;
      stepCycle();
      cmdRdy = 1'b0;
      checkValue("moving", 32'(moving), 32'd0);
    end
    checkValue("desiredHeading", 32'(desiredHeading), 32'(hdgExp));
    headingErr = '0;
    waitCnt = 0;
    while (!moving && (waitCnt < WAIT_LIMIT)) begin
      stepCycle();
      waitCnt++;
    end
    if (!moving) begin
      reportTimeout("moving after heading settle");
      return;
    end
    // Zero error must hold for the whole settle window
    checkValue("settle cycles", 32'(waitCnt), 32'(SETTLE_CYCLES));

    ////////////////////////////////////////////////////////////////////
    // Line crossings with jittered gaps
    ////////////////////////////////////////////////////////////////////
    for (k = 0; k < lineTarget; k++) begin
      rngState = nextRandom(rngState);
      gap      = gapBase + int'(rngState[1:0]);
      for (i = 0; i < gap; i++) begin
        stepCycle();
      end
      if (k == lineTarget - 1) begin
        lastDriven = 1'b1;
      end
      lineCross = 1'b1;
      pulseCount++;
      // Mid-move command is dropped without a response
      if (k == 0) begin
        sendCommand(STRAY_CMD);
      end
      stepCycle();
      lineCross = 1'b0;
      cmdRdy    = 1'b0;
    end
    waitCnt = 0;
    while (!sendResp && (waitCnt < WAIT_LIMIT)) begin
      stepCycle();
      waitCnt++;
    end
    if (!sendResp) begin
      reportTimeout("move response");
      return;
    end
    checkValue("resp", 32'(resp), 32'(expResp));
    checkValue("frwrdSpeed", 32'(frwrdSpeed), 32'd0);
    checkValue("moving", 32'(moving), 32'd0);
  endtask

  task automatic runRejectCase(input logic [CMD_W-1:0] word,
                               input logic [RESP_W-1:0] expResp);
    sendCommand(word);
    stepCycle();
    cmdRdy = 1'b0;
    checkValue("sendResp", 32'(sendResp), 32'd0);
    // NAK one cycle after decode
    stepCycle();
    checkValue("sendResp", 32'(sendResp), 32'd1);
    checkValue("resp", 32'(resp), 32'(expResp));
    checkValue("strtCal", 32'(strtCal), 32'd0);
  endtask

  // Quiet line after each command and exactly one response overall
  task automatic idleAfterCase();
    int i;
    for (i = 0; i < 4; i++) begin
      stepCycle();
      // A stray line pulse while idle must change nothing
      lineCross = (i == 0);
      checkValue("sendResp", 32'(sendResp), 32'd0);
      checkValue("moving", 32'(moving), 32'd0);
      checkValue("frwrdSpeed", 32'(frwrdSpeed), 32'd0);
    end
    lineCross = 1'b0;
    checkValue("response count", 32'(respCount), 32'd1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int               fd;
    int               rc;
    int               n;
    int               caseNum;
    string            line;
    logic [CMD_W-1:0] word;
    int               gyroDelay;
    int               settleLen;
    int               gapBase;
    logic [RESP_W-1:0] expResp;
    rstN       = 1'b0;
    cmd        = '0;
    cmdRdy     = 1'b0;
    calDone    = 1'b0;
    headingErr = '0;
    lineCross  = 1'b0;
    checkCount = 0;
    errCount   = 0;
    abortCount = 0;
    respCount  = 0;
    pulseCount = 0;
    lineTarget = 0;
    lastDriven = 1'b0;
    prevMoving = 1'b0;
    prevSpeed  = '0;
    rngState   = 32'hd259ac32;
    caseNum    = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    // Outputs at their reset values
    checkValue("strtCal", 32'(strtCal), 32'd0);
    checkValue("moving", 32'(moving), 32'd0);
    checkValue("sendResp", 32'(sendResp), 32'd0);
    checkValue("frwrdSpeed", 32'(frwrdSpeed), 32'd0);
    checkValue("resp", 32'(resp), 32'd0);
    checkValue("desiredHeading", 32'(desiredHeading), 32'd0);
    rstN = 1'b1;
    fd = $fopen("testbench/cmdCases.txt", "r");
    if (fd == 0) begin
      $display("Could not open testbench/cmdCases.txt");
      abortCount++;
    end else begin
      while (!$feof(fd) && (abortCount == 0)) begin
        rc = $fgets(line, fd);
        // Skip blank and comment lines
        if ((rc == 0) || (line.len() < 2) || (line.substr(0, 1) == "//")) begin
          continue;
        end
        n = $sscanf(line, "%h %d %d %d %h", word, gyroDelay, settleLen, gapBase, expResp);
        if (n != 5) begin
          $display("Malformed line in the cases file: %s", line);
          abortCount++;
        end else begin
          caseNum++;
          respCount  = 0;
          lastDriven = 1'b0;
          $display("Case %0d command 0x%h", caseNum, word);
          if (word[CMD_W-1 -: OPC_W] == OPC_CAL) begin
            runCalCase(word, gyroDelay, expResp);
          end else if ((word[CMD_W-1 -: OPC_W] == OPC_MOVE) && (word[3:0] != 4'h0)) begin
            runMoveCase(word, settleLen, gapBase, expResp);
          end else begin
            runRejectCase(word, expResp);
          end
          if (abortCount == 0) begin
            idleAfterCase();
          end
        end
      end
      $fclose(fd);
      if (caseNum == 0) begin
        $display("No cases found in the cases file");
        abortCount++;
      end
    end
    $display("Cases %0d, checks %0d, value errors %0d, other failures %0d",
             caseNum, checkCount, errCount, abortCount);
    if ((errCount == 0) && (abortCount == 0)) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* testbench/cmdCases.txt */
// cmd gyroDelay settleLen lineGap expResp
// cmd and expResp in hex, the three timing columns in decimal clocks
2000 3 0 0 A5
4A53 0 2 1 A5
7123 0 0 0 5A
4001 0 5 2 A5
2FFF 1 0 0 A5
4120 0 0 0 5A
4FF2 0 3 1 A5
0000 0 0 0 5A
4804 0 9 3 A5
3456 0 0 0 5A
2000 6 0 0 A5
47F1 0 2 4 A5
F00F 0 0 0 5A
400F 0 4 1 A5
5001 0 0 0 5A
4C08 0 12 2 A5
2ABC 2 0 0 A5
4FF0 0 0 0 5A
4305 0 7 1 A5
1FFF 0 0 0 5A
430F 0 3 5 A5

/* src.f */
common/knightPkg.sv
verilog/cmdDecode.sv
moveExecute/speedRamp.sv
moveExecute/moveExecute.sv
verilog/respGen.sv
verilog/knightCmdCore.sv
testbench/knightCmdCore_tb.sv

/* Makefile */
# Verilator flow for the knight command core

VERILATOR ?= verilator
TOP       ?= knightCmdCore_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Simulation FAILED
VFLAGS    ?= --timing --assert -Wno-fatal
JOBS      ?= 4

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Failure reported in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
